// ==== logic/tank_pkg.sv ====
package tank_pkg;

    typedef logic [9:0]  pos_t;     // screen coordinate
    typedef logic [29:0] rgb_t;     // 10 bits per channel, r g b

    typedef enum logic [1:0] {
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_t;

    typedef enum logic {
        BULLET_IDLE,
        BULLET_FLYING
    } bullet_state_t;

    // start of vertical retrace
    localparam pos_t TICK_X = 10'd0;
    localparam pos_t TICK_Y = 10'd491;

    // limits for the tank's top-left corner
    localparam pos_t ARENA_LEFT   = 10'd32;
    localparam pos_t ARENA_RIGHT  = 10'd576;
    localparam pos_t ARENA_TOP    = 10'd32;
    localparam pos_t ARENA_BOTTOM = 10'd416;

    // bullet top-left corner must stay inside these
    localparam pos_t BULLET_MIN   = 10'd28;
    localparam pos_t BULLET_MAX_X = 10'd607;
    localparam pos_t BULLET_MAX_Y = 10'd447;

    localparam pos_t TANK_START_X = 10'd32;
    localparam pos_t TANK_START_Y = 10'd416;

    // playfield bands, x range is half open
    localparam pos_t BAND_X_LO        = 10'd32;
    localparam pos_t BAND_X_HI        = 10'd608;
    localparam pos_t BAND_ROAD_TOP_LO = 10'd31;
    localparam pos_t BAND_SAND_TOP_LO = 10'd68;
    localparam pos_t BAND_WATER_LO    = 10'd228;
    localparam pos_t BAND_SAND_LO     = 10'd260;
    localparam pos_t BAND_ROAD_LO     = 10'd420;
    localparam pos_t BAND_END         = 10'd452;

    localparam rgb_t RED        = {10'h3FF, 10'h000, 10'h000};
    localparam rgb_t YELLOW     = {10'h3FF, 10'h3FF, 10'h000};
    localparam rgb_t BLUE       = {10'h000, 10'h000, 10'h3FF};
    localparam rgb_t BLACK      = {10'h000, 10'h000, 10'h000};
    localparam rgb_t SAND_COLOR = {10'h3C0, 10'h300, 10'h180};
    localparam rgb_t WALL_COLOR = {10'h000, 10'h280, 10'h000};   // green wall

endpackage

// ==== logic/tank_motion.sv ====
`timescale 1ns/1ps

module tank_motion
    import tank_pkg::*;
#(
    parameter int TANK_SIZE = 32,
    parameter int TANK_STEP = 1
) (
    input  logic clk_50MHz,
    input  logic reset,
    input  logic up,
    input  logic down,
    input  logic left,
    input  logic right,
    input  pos_t x,
    input  pos_t y,
    output logic refresh_tick,
    output pos_t tank_x,
    output pos_t tank_y,
    output dir_t tank_dir
);

    localparam pos_t STEP = pos_t'(TANK_STEP);
    localparam pos_t SIZE = pos_t'(TANK_SIZE);
    // far edges of the square when parked at the right or bottom limit
    localparam pos_t RIGHT_EDGE_MAX  = ARENA_RIGHT + SIZE - 10'd1;
    localparam pos_t BOTTOM_EDGE_MAX = ARENA_BOTTOM + SIZE - 10'd1;

    logic at_tick;      // scan sits on the retrace position
    logic at_tick_q;
    pos_t far_x;
    pos_t far_y;
    pos_t x_next;
    pos_t y_next;
    dir_t dir_next;

    assign at_tick = (x == TICK_X) && (y == TICK_Y);
    assign far_x   = tank_x + SIZE - 10'd1;
    assign far_y   = tank_y + SIZE - 10'd1;

    // first pressed button wins, facing follows it even when blocked
    always_comb begin
        x_next   = tank_x;
        y_next   = tank_y;
        dir_next = tank_dir;
        if (up) begin
            dir_next = DIR_UP;
            if (tank_y >= ARENA_TOP + STEP)
                y_next = tank_y - STEP;
        end else if (down) begin
            dir_next = DIR_DOWN;
            if (far_y + STEP <= BOTTOM_EDGE_MAX)
                y_next = tank_y + STEP;
        end else if (left) begin
            dir_next = DIR_LEFT;
            if (tank_x >= ARENA_LEFT + STEP)
                x_next = tank_x - STEP;
        end else if (right) begin
            dir_next = DIR_RIGHT;
            if (far_x + STEP <= RIGHT_EDGE_MAX)
                x_next = tank_x + STEP;
        end
    end

    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            at_tick_q    <= 1'b0;
            refresh_tick <= 1'b0;
            tank_x       <= TANK_START_X;
            tank_y       <= TANK_START_Y;
            tank_dir     <= DIR_UP;
        end else begin
            at_tick_q    <= at_tick;
            refresh_tick <= at_tick && !at_tick_q;   // one pulse per frame
            if (refresh_tick) begin
                tank_x   <= x_next;
                tank_y   <= y_next;
                tank_dir <= dir_next;
            end
        end
    end

endmodule

// ==== logic/bullet_ctrl.sv ====
`timescale 1ns/1ps

module bullet_ctrl
    import tank_pkg::*;
#(
    parameter int TANK_SIZE   = 32,
    parameter int BULLET_SIZE = 4,
    parameter int BULLET_STEP = 8
) (
    input  logic clk_50MHz,
    input  logic reset,
    input  logic refresh_tick,
    input  logic shot,
    input  pos_t tank_x,
    input  pos_t tank_y,
    input  dir_t tank_dir,
    output pos_t bullet_x,
    output pos_t bullet_y
);

    // offset that puts the bullet square in the middle of the tank
    localparam pos_t CENTRE = pos_t'(TANK_SIZE / 2 - BULLET_SIZE / 2);
    localparam pos_t STEP   = pos_t'(BULLET_STEP);

    bullet_state_t state;
    bullet_state_t state_next;
    dir_t          shot_dir;    // direction latched at launch
    dir_t          dir_next;
    pos_t          bx_next;
    pos_t          by_next;

    always_comb begin
        state_next = state;
        dir_next   = shot_dir;
        bx_next    = bullet_x;
        by_next    = bullet_y;
        case (state)
            BULLET_IDLE: begin
                // rides along with the tank until fired
                bx_next  = tank_x + CENTRE;
                by_next  = tank_y + CENTRE;
                dir_next = tank_dir;
                if (shot)
                    state_next = BULLET_FLYING;
            end
            BULLET_FLYING: begin
                case (shot_dir)
                    DIR_UP:    by_next = bullet_y - STEP;
                    DIR_DOWN:  by_next = bullet_y + STEP;
                    DIR_LEFT:  bx_next = bullet_x - STEP;
                    DIR_RIGHT: bx_next = bullet_x + STEP;
                endcase
                // wrap below zero lands above the max limits
                if (bx_next < BULLET_MIN || bx_next > BULLET_MAX_X ||
                    by_next < BULLET_MIN || by_next > BULLET_MAX_Y)
                    state_next = BULLET_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            state    <= BULLET_IDLE;
            shot_dir <= DIR_UP;
            bullet_x <= TANK_START_X + CENTRE;
            bullet_y <= TANK_START_Y + CENTRE;
        end else if (refresh_tick) begin
            state    <= state_next;
            shot_dir <= dir_next;
            bullet_x <= bx_next;
            bullet_y <= by_next;
        end
    end

endmodule

// ==== logic/background_map.sv ====
`timescale 1ns/1ps

module background_map
    import tank_pkg::*;
(
    input  pos_t x,
    input  pos_t y,
    output rgb_t bg_rgb
);

    logic in_field;     // inside the horizontal band range

    assign in_field = (x >= BAND_X_LO) && (x < BAND_X_HI);

    // bands stacked top to bottom, wall outside them
    always_comb begin
        bg_rgb = WALL_COLOR;
        if (in_field) begin
            if (y < BAND_ROAD_TOP_LO)
                bg_rgb = WALL_COLOR;
            else if (y < BAND_SAND_TOP_LO)
                bg_rgb = BLACK;         // upper road
            else if (y < BAND_WATER_LO)
                bg_rgb = SAND_COLOR;
            else if (y < BAND_SAND_LO)
                bg_rgb = BLUE;          // river
            else if (y < BAND_ROAD_LO)
                bg_rgb = SAND_COLOR;
            else if (y < BAND_END)
                bg_rgb = BLACK;         // lower road
        end
    end

endmodule

// ==== logic/pixel_mux.sv ====
`timescale 1ns/1ps

module pixel_mux
    import tank_pkg::*;
#(
    parameter int TANK_SIZE   = 32,
    parameter int BULLET_SIZE = 4
) (
    input  logic video_on,
    input  pos_t x,
    input  pos_t y,
    input  pos_t tank_x,
    input  pos_t tank_y,
    input  pos_t bullet_x,
    input  pos_t bullet_y,
    input  rgb_t bg_rgb,
    output rgb_t rgb
);

    localparam pos_t TANK_LAST   = pos_t'(TANK_SIZE - 1);
    localparam pos_t BULLET_LAST = pos_t'(BULLET_SIZE - 1);

    logic tank_on;
    logic bullet_on;

    // inclusive square bounds
    assign tank_on = (x >= tank_x) && (x <= tank_x + TANK_LAST) &&
                     (y >= tank_y) && (y <= tank_y + TANK_LAST);

    assign bullet_on = (x >= bullet_x) && (x <= bullet_x + BULLET_LAST) &&
                       (y >= bullet_y) && (y <= bullet_y + BULLET_LAST);

    always_comb begin
        if (!video_on)
            rgb = BLACK;        // blanking
        else if (tank_on)
            rgb = YELLOW;
        else if (bullet_on)
            rgb = RED;
        else
            rgb = bg_rgb;
    end

endmodule

// ==== logic/tank_game_top.sv ====
`timescale 1ns/1ps

module tank_game_top
    import tank_pkg::*;
#(
    parameter int TANK_SIZE   = 32,
    parameter int TANK_STEP   = 1,
    parameter int BULLET_SIZE = 4,
    parameter int BULLET_STEP = 8
) (
    input  logic clk_50MHz,
    input  logic reset,
    input  logic up,
    input  logic down,
    input  logic left,
    input  logic right,
    input  logic shot,
    input  logic video_on,
    input  pos_t x,
    input  pos_t y,
    output rgb_t rgb
);

    logic refresh_tick;     // once per frame
    pos_t tank_x;
    pos_t tank_y;
    dir_t tank_dir;
    pos_t bullet_x;
    pos_t bullet_y;
    rgb_t bg_rgb;

    tank_motion #(
        .TANK_SIZE (TANK_SIZE),
        .TANK_STEP (TANK_STEP)
    ) tank_motion_i (
        .clk_50MHz    (clk_50MHz),
        .reset        (reset),
        .up           (up),
        .down         (down),
        .left         (left),
        .right        (right),
        .x            (x),
        .y            (y),
        .refresh_tick (refresh_tick),
        .tank_x       (tank_x),
        .tank_y       (tank_y),
        .tank_dir     (tank_dir)
    );

    bullet_ctrl #(
        .TANK_SIZE   (TANK_SIZE),
        .BULLET_SIZE (BULLET_SIZE),
        .BULLET_STEP (BULLET_STEP)
    ) bullet_ctrl_i (
        .clk_50MHz    (clk_50MHz),
        .reset        (reset),
        .refresh_tick (refresh_tick),
        .shot         (shot),
        .tank_x       (tank_x),
        .tank_y       (tank_y),
        .tank_dir     (tank_dir),
        .bullet_x     (bullet_x),
        .bullet_y     (bullet_y)
    );

    background_map background_map_i (
        .x      (x),
        .y      (y),
        .bg_rgb (bg_rgb)
    );

    pixel_mux #(
        .TANK_SIZE   (TANK_SIZE),
        .BULLET_SIZE (BULLET_SIZE)
    ) pixel_mux_i (
        .video_on (video_on),
        .x        (x),
        .y        (y),
        .tank_x   (tank_x),
        .tank_y   (tank_y),
        .bullet_x (bullet_x),
        .bullet_y (bullet_y),
        .bg_rgb   (bg_rgb),
        .rgb      (rgb)
    );

endmodule

// ==== sim/tank_game_assert.sv ====
`timescale 1ns/1ps

module tank_motion_assert
    import tank_pkg::*;
(
    input logic clk_50MHz,
    input logic reset,
    input logic refresh_tick,
    input pos_t tank_x,
    input pos_t tank_y
);

    int violations = 0;     // read by the testbench summary

    arena_limits: assert property (@(posedge clk_50MHz) disable iff (!reset)
        tank_x >= ARENA_LEFT && tank_x <= ARENA_RIGHT &&
        tank_y >= ARENA_TOP && tank_y <= ARENA_BOTTOM)
        else begin
            $error("tank position is outside the arena limits");
            violations++;
        end

    // moves only on the edge where the tick was high
    move_on_tick: assert property (@(posedge clk_50MHz) disable iff (!reset)
        ((tank_x != $past(tank_x)) || (tank_y != $past(tank_y))) |-> $past(refresh_tick))
        else begin
            $error("tank moved without a refresh tick");
            violations++;
        end

    single_tick: assert property (@(posedge clk_50MHz) disable iff (!reset)
        refresh_tick |=> !refresh_tick)
        else begin
            $error("refresh tick stayed high for two cycles");
            violations++;
        end

endmodule

bind tank_motion tank_motion_assert tank_motion_assert_i (
    .clk_50MHz    (clk_50MHz),
    .reset        (reset),
    .refresh_tick (refresh_tick),
    .tank_x       (tank_x),
    .tank_y       (tank_y)
);

// ==== sim/tank_game_tb.sv ====
`timescale 1ns/1ps

module tank_game_tb
    import tank_pkg::*;
();

    localparam int   NUM_ROWS = 23;
    localparam pos_t PARK_X   = 10'd640;    // scan parked off the retrace spot
    localparam pos_t PARK_Y   = 10'd0;

    logic clk_50MHz = 1'b0;
    logic reset;
    logic up;
    logic down;
    logic left;
    logic right;
    logic shot;
    logic video_on;
    pos_t x;
    pos_t y;
    rgb_t rgb;

    // stimulus table with one entry per test
    string      row_name   [NUM_ROWS];
    logic [4:0] row_btn    [NUM_ROWS];  // up down left right shot
    int         row_frames [NUM_ROWS];
    pos_t       row_px     [NUM_ROWS];
    pos_t       row_py     [NUM_ROWS];
    logic       row_video  [NUM_ROWS];
    rgb_t       row_exp    [NUM_ROWS];
    int         row_count  = 0;
    int         pass_count = 0;
    int         fail_count = 0;

    tank_game_top tank_game_top_i (
        .clk_50MHz (clk_50MHz),
        .reset     (reset),
        .up        (up),
        .down      (down),
        .left      (left),
        .right     (right),
        .shot      (shot),
        .video_on  (video_on),
        .x         (x),
        .y         (y),
        .rgb       (rgb)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    task automatic add_row(input string name, input logic [4:0] btn, input int frames,
                           input pos_t px, input pos_t py, input logic von, input rgb_t exp);
        row_name[row_count]   = name;
        row_btn[row_count]    = btn;
        row_frames[row_count] = frames;
        row_px[row_count]     = px;
        row_py[row_count]     = py;
        row_video[row_count]  = von;
        row_exp[row_count]    = exp;
        row_count++;
    endtask

    // tank starts at (32,416) with the bullet at its centre until fired
    task automatic load_table();
        add_row("reset_tank",    5'b00000, 0,  10'd32,  10'd416, 1'b1, YELLOW);
        add_row("reset_wall",    5'b00000, 0,  10'd31,  10'd416, 1'b1, WALL_COLOR);
        add_row("blank_tank",    5'b00000, 0,  10'd32,  10'd416, 1'b0, BLACK);
        add_row("move_right",    5'b00010, 5,  10'd68,  10'd420, 1'b1, YELLOW);
        add_row("road_behind",   5'b00000, 0,  10'd36,  10'd420, 1'b1, BLACK);
        add_row("move_left",     5'b00100, 5,  10'd64,  10'd420, 1'b1, BLACK);
        add_row("left_blocked",  5'b00100, 10, 10'd63,  10'd420, 1'b1, YELLOW);
        add_row("up_right",      5'b10010, 3,  10'd32,  10'd413, 1'b1, YELLOW);
        add_row("up_only",       5'b00000, 0,  10'd32,  10'd445, 1'b1, BLACK);
        add_row("band_sand_top", 5'b00000, 0,  10'd320, 10'd100, 1'b1, SAND_COLOR);
        add_row("band_water",    5'b00000, 0,  10'd320, 10'd240, 1'b1, BLUE);
        add_row("band_sand_low", 5'b00000, 0,  10'd320, 10'd300, 1'b1, SAND_COLOR);
        add_row("band_road_low", 5'b00000, 0,  10'd320, 10'd430, 1'b1, BLACK);
        // probe parked on the retrace spot for three clocks gives a single tick
        add_row("hold_tick",     5'b10000, 0,  10'd0,   10'd491, 1'b1, WALL_COLOR);
        add_row("aim_up",        5'b10000, 0,  10'd32,  10'd443, 1'b1, YELLOW);
        add_row("fire",          5'b00001, 1,  10'd32,  10'd412, 1'b1, YELLOW);
        // bullet top-left is (46, 426 - 8k) after k frames of flight
        add_row("fly_3",         5'b00000, 3,  10'd46,  10'd402, 1'b1, RED);
        add_row("fly_4",         5'b00000, 1,  10'd46,  10'd394, 1'b1, RED);
        add_row("fly_trail",     5'b00000, 0,  10'd46,  10'd402, 1'b1, SAND_COLOR);
        add_row("fly_49",        5'b00000, 45, 10'd46,  10'd34,  1'b1, RED);
        add_row("bullet_exit",   5'b00000, 2,  10'd46,  10'd34,  1'b1, BLACK);
        add_row("bullet_home",   5'b00000, 0,  10'd46,  10'd26,  1'b1, WALL_COLOR);
        add_row("bullet_idle",   5'b00000, 0,  10'd46,  10'd18,  1'b1, WALL_COLOR);
    endtask

    task automatic next_slot();
        @(posedge clk_50MHz);
        #2;
    endtask

    // retrace position for one clock before the scan moves away
    task automatic run_frame();
        next_slot();
        x = TICK_X;
        y = TICK_Y;
        next_slot();
        x = PARK_X;
        y = PARK_Y;
        next_slot();
    endtask

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("PASS   %s rgb %h", name, actual);
        end else begin
            fail_count++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    initial begin
        int assert_fails;
        reset    = 1'b0;
        up       = 1'b0;
        down     = 1'b0;
        left     = 1'b0;
        right    = 1'b0;
        shot     = 1'b0;
        video_on = 1'b1;
        x        = PARK_X;
        y        = PARK_Y;
        load_table();
        repeat (5) @(posedge clk_50MHz);
        #2;
        reset = 1'b1;
        for (int i = 0; i < row_count; i++) begin
            next_slot();
            {up, down, left, right, shot} = row_btn[i];
            repeat (row_frames[i]) run_frame();
            next_slot();
            x        = row_px[i];
            y        = row_py[i];
            video_on = row_video[i];
            @(posedge clk_50MHz);
            #1;
            check_rgb(row_name[i], row_exp[i], rgb);
        end
        assert_fails = tank_game_top_i.tank_motion_i.tank_motion_assert_i.violations;
        fail_count += assert_fails;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 row_count, pass_count, fail_count - assert_fails, assert_fails);
        if (fail_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int    max_frames;
        longint limit_ns;
        #1;
        max_frames = 0;
        for (int i = 0; i < row_count; i++)
            if (row_frames[i] > max_frames)
                max_frames = row_frames[i];
        limit_ns = longint'(row_count * max_frames * 3 + 50) * 20 * 2;
        #(limit_ns);
        $display("timeout: the test sequence did not finish within %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/tank_pkg.sv
logic/tank_motion.sv
logic/bullet_ctrl.sv
logic/background_map.sv
logic/pixel_mux.sv
logic/tank_game_top.sv
sim/tank_game_assert.sv
sim/tank_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the tank game testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tank_game_tb --Mdir "$OBJ" -o tank_game_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/tank_game_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0
